// File: verilog/sine_table.svh
`ifndef SINE_TABLE_SVH
`define SINE_TABLE_SVH

// First quadrant of sine, entry k is LO_AMP * sin(k * pi / 64)
// Entry for pi/2 is not stored, the DDS substitutes LO_AMP
localparam logic [16:0] SINE_TABLE [0:(1 << rf_dsp_pkg::TABLE_BITS) - 1] = '{
	17'd0,
	17'd3665,
	17'd7321,
	17'd10960,
	17'd14572,
	17'd18149,
	17'd21683,
	17'd25164,
	17'd28584,
	17'd31936,
	17'd35211,
	17'd38400,
	17'd41498,
	17'd44495,
	17'd47385,
	17'd50161,
	17'd52817,
	17'd55345,
	17'd57739,
	17'd59995,
	17'd62106,
	17'd64067,
	17'd65874,
	17'd67523,
	17'd69008,
	17'd70328,
	17'd71478,
	17'd72456,
	17'd73259,
	17'd73886,
	17'd74334,
	17'd74604
};

`endif

// File: verilog/rf_dsp_pkg.sv
package rf_dsp_pkg;

	// Signal path sample formats
	typedef logic signed [15:0] adc_t;
	typedef logic signed [17:0] lo_t;
	typedef logic signed [17:0] xy_t;
	typedef logic signed [17:0] drive_t;
	typedef logic signed [19:0] mon_t;

	// Monitor FIFO entry, boundary flag marks the I word
	typedef struct packed {
		logic boundary;
		mon_t data;
	} mon_word_t;

	// Largest drive magnitude after saturation
	localparam int DRIVE_MAX = 131071;
	// Right shift after the gain product
	localparam int FDBK_SHIFT = 8;
	// Quarter-wave table index width
	localparam int TABLE_BITS = 5;

endpackage

// File: verilog/rf_ctl_pkg.sv
package rf_ctl_pkg;

	// Clocks per CIC sample, IF = clk * 7/33
	localparam int CIC_BASE_PERIOD = 33;

	// LO peak amplitude in lo_t counts
	localparam int LO_AMP = 74694;

	// State divider load values on fiber sync
	localparam logic [2:0] SYNC_STATE_NORMAL = 3'd2;
	// I and Q interchanged
	localparam logic [2:0] SYNC_STATE_SWAP = 3'd1;

	// Entries per stream FIFO, power of two
	localparam int FIFO_DEPTH = 8;

endpackage

// File: verilog/rf_timing.sv
`timescale 1ns/1ps

module rf_timing (
	input  logic       clk,
	input  logic       ctlr_ph_reset,
	input  logic       qsync_rx,
	input  logic [1:0] use_fiber_iq,
	input  logic [7:0] wave_samp_per,
	output logic       iq,
	output logic       cic_tick,
	output logic       wave_strobe,
	output logic       dds_reset
);

	logic [2:0] state;
	logic [5:0] cic_cnt;
	logic [7:0] wave_cnt;
	logic       dds_req;
	logic       state_load;
	logic [2:0] sync_state;

	// Fiber frame sync reloads the divider
	assign state_load = qsync_rx & use_fiber_iq[0];
	// Swapped I/Q flips handedness, so load one state earlier
	assign sync_state = use_fiber_iq[1] ? rf_ctl_pkg::SYNC_STATE_SWAP
		: rf_ctl_pkg::SYNC_STATE_NORMAL;

	always_ff @(posedge clk) begin
		if (ctlr_ph_reset) begin
			state <= 3'd0;
		end else if (state_load) begin
			state <= sync_state;
		end else begin
			state <= state + 3'd1;
		end
	end

	// I on even states, Q on odd
	assign iq = state[0];

	// CIC rate counter, tick registered
	always_ff @(posedge clk) begin
		if (ctlr_ph_reset) begin
			cic_cnt  <= 6'd0;
			cic_tick <= 1'b0;
		end else if (cic_cnt == 6'(rf_ctl_pkg::CIC_BASE_PERIOD - 1)) begin
			cic_cnt  <= 6'd0;
			cic_tick <= 1'b1;
		end else begin
			cic_cnt  <= cic_cnt + 6'd1;
			cic_tick <= 1'b0;
		end
	end

	// Waveform decimation, one strobe per wave_samp_per ticks
	always_ff @(posedge clk) begin
		if (ctlr_ph_reset) begin
			wave_cnt <= 8'd0;
		end else if (cic_tick) begin
			wave_cnt <= (wave_cnt <= 8'd1) ? wave_samp_per : wave_cnt - 8'd1;
		end
	end

	assign wave_strobe = cic_tick & (wave_cnt == 8'd1);

	// Phase reset request held until the next CIC boundary
	// Reset arms it, realignment follows once reset drops
	always_ff @(posedge clk) begin
		if (ctlr_ph_reset) begin
			dds_req   <= 1'b1;
			dds_reset <= 1'b0;
		end else begin
			dds_reset <= cic_tick & dds_req;
			if (cic_tick) begin
				dds_req <= 1'b0;
			end
		end
	end

endmodule

// File: verilog/phase_dds.sv
`timescale 1ns/1ps

module phase_dds (
	input  logic              clk,
	input  logic              ctlr_ph_reset,
	input  logic              dds_reset,
	input  logic [31:0]       phase_step,
	input  logic [11:0]       modulo,
	output rf_dsp_pkg::lo_t   cosa,
	output rf_dsp_pkg::lo_t   sina
);

`include "sine_table.svh"

	logic [19:0] phase_h;
	logic [11:0] phase_l;
	logic [12:0] sum_l;
	logic [12:0] sum_m;
	logic        wrap;
	logic [1:0]  quad;
	logic [rf_dsp_pkg::TABLE_BITS-1:0] idx;

	// Fold one quadrant of the table onto the full circle
	function automatic rf_dsp_pkg::lo_t fold(
		input logic [1:0] q,
		input logic [rf_dsp_pkg::TABLE_BITS-1:0] i
	);
		logic [16:0] mag;
		logic [rf_dsp_pkg::TABLE_BITS-1:0] mirror_i;
		mirror_i = '0 - i;
		// Odd quadrants run the table backwards
		if (q[0]) begin
			mag = (i == '0) ? 17'(rf_ctl_pkg::LO_AMP) : SINE_TABLE[mirror_i];
		end else begin
			mag = SINE_TABLE[i];
		end
		// Lower half circle is negative
		return q[1] ? -rf_dsp_pkg::lo_t'({1'b0, mag}) : rf_dsp_pkg::lo_t'({1'b0, mag});
	endfunction

	// Low part wraps early by modulo, carry into high part
	assign sum_l = {1'b0, phase_l} + {1'b0, phase_step[11:0]};
	assign sum_m = sum_l + {1'b0, modulo};
	assign wrap  = sum_m[12];

	always_ff @(posedge clk) begin
		if (ctlr_ph_reset || dds_reset) begin
			phase_h <= 20'd0;
			phase_l <= 12'd0;
		end else begin
			phase_l <= wrap ? sum_m[11:0] : sum_l[11:0];
			phase_h <= phase_h + phase_step[31:12] + {19'd0, wrap};
		end
	end

	// Top phase bits: quadrant then table index
	assign quad = phase_h[19:18];
	assign idx  = phase_h[17 -: rf_dsp_pkg::TABLE_BITS];

	// Cosine leads sine by one quadrant
	always_ff @(posedge clk) begin
		cosa <= fold(quad + 2'd1, idx);
		sina <= fold(quad, idx);
	end

endmodule

// File: verilog/iq_downconvert.sv
`timescale 1ns/1ps

module iq_downconvert (
	input  logic            clk,
	input  logic            ctlr_ph_reset,
	input  logic            iq,
	input  rf_dsp_pkg::adc_t a_field,
	input  rf_dsp_pkg::lo_t  cosa,
	input  rf_dsp_pkg::lo_t  sina,
	output rf_dsp_pkg::xy_t  field_xy
);

	logic signed [33:0] prod;
	rf_dsp_pkg::lo_t    lo_sel;

	// Cosine on I states, sine on Q states
	assign lo_sel = iq ? sina : cosa;

	// Stage 1, mixer product
	always_ff @(posedge clk) begin
		prod <= a_field * lo_sel;
	end

	// Stage 2, round to xy width
	// Product peak stays below 2^32, so bits 32:15 hold the result
	always_ff @(posedge clk) begin
		if (ctlr_ph_reset) begin
			field_xy <= '0;
		end else begin
			field_xy <= prod[32:15] + {17'd0, prod[14]};
		end
	end

endmodule

// File: verilog/fdbk_prop.sv
`timescale 1ns/1ps

module fdbk_prop (
	input  logic               clk,
	input  logic               ctlr_ph_reset,
	input  logic               iq,
	input  rf_dsp_pkg::xy_t    in_xy,
	input  rf_dsp_pkg::xy_t    set_x,
	input  rf_dsp_pkg::xy_t    set_y,
	input  logic signed [15:0] gain,
	output rf_dsp_pkg::drive_t out_xy
);

	rf_dsp_pkg::xy_t    setpt;
	logic signed [18:0] err;
	logic signed [34:0] prod_d;
	logic signed [34:0] prod_q;
	logic signed [34:0] shifted;

	// Setpoint follows the interleave
	assign setpt = iq ? set_y : set_x;
	// One extra bit so the difference never wraps
	assign err    = 19'(setpt) - 19'(in_xy);
	assign prod_d = err * gain;

	// Stage 1, error times gain
	always_ff @(posedge clk) begin
		if (ctlr_ph_reset) begin
			prod_q <= '0;
		end else begin
			prod_q <= prod_d;
		end
	end

	assign shifted = prod_q >>> rf_dsp_pkg::FDBK_SHIFT;

	// Stage 2, clip symmetric to the drive range
	always_ff @(posedge clk) begin
		if (ctlr_ph_reset) begin
			out_xy <= '0;
		end else if (shifted > rf_dsp_pkg::DRIVE_MAX) begin
			out_xy <= rf_dsp_pkg::drive_t'(rf_dsp_pkg::DRIVE_MAX);
		end else if (shifted < -rf_dsp_pkg::DRIVE_MAX) begin
			out_xy <= rf_dsp_pkg::drive_t'(-rf_dsp_pkg::DRIVE_MAX);
		end else begin
			out_xy <= shifted[17:0];
		end
	end

endmodule

// File: verilog/wave_decimator.sv
`timescale 1ns/1ps

module wave_decimator (
	input  logic               clk,
	input  logic               ctlr_ph_reset,
	input  logic               wave_strobe,
	input  logic               iq,
	input  rf_dsp_pkg::xy_t    in_xy,
	input  rf_dsp_pkg::drive_t drive,
	input  logic [2:0]         wave_shift,
	output rf_dsp_pkg::mon_t   mon_data,
	output logic               mon_boundary,
	output logic               mon_push,
	input  logic               mon_space2,
	output rf_dsp_pkg::drive_t trace_data,
	output logic               trace_push,
	input  logic               trace_space,
	output logic               mon_overrun,
	output logic               trace_overrun
);

	logic armed;
	logic q_next;
	logic take_i;

	// Sign extend, then scale down
	function automatic rf_dsp_pkg::mon_t scale_word(
		input rf_dsp_pkg::xy_t w,
		input logic [2:0] sh
	);
		rf_dsp_pkg::mon_t ext;
		ext = rf_dsp_pkg::mon_t'(w);
		return ext >>> sh;
	endfunction

	// Pair starts on the first I state at or after the strobe
	assign take_i = (armed | wave_strobe) & ~iq & ~q_next;

	always_ff @(posedge clk) begin
		if (ctlr_ph_reset) begin
			armed         <= 1'b0;
			q_next        <= 1'b0;
			mon_push      <= 1'b0;
			trace_push    <= 1'b0;
			mon_overrun   <= 1'b0;
			trace_overrun <= 1'b0;
		end else begin
			mon_push   <= 1'b0;
			trace_push <= 1'b0;
			// Trace word, one per strobe
			if (wave_strobe) begin
				trace_push <= trace_space;
				if (!trace_space) begin
					trace_overrun <= 1'b1;
				end
			end
			// Q follows I on the next cycle
			if (q_next) begin
				mon_push <= 1'b1;
				q_next   <= 1'b0;
			end else if (take_i) begin
				armed <= 1'b0;
				// Whole pair or nothing
				if (mon_space2) begin
					mon_push <= 1'b1;
					q_next   <= 1'b1;
				end else begin
					mon_overrun <= 1'b1;
				end
			end else if (wave_strobe) begin
				armed <= 1'b1;
			end
		end
	end

	// Output words
	always_ff @(posedge clk) begin
		if (wave_strobe) begin
			trace_data <= drive;
		end
		if (q_next || take_i) begin
			mon_data     <= scale_word(in_xy, wave_shift);
			mon_boundary <= take_i;
		end
	end

endmodule

// File: verilog/stream_fifo.sv
`timescale 1ns/1ps

module stream_fifo #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     ctlr_ph_reset,
	input  logic     push,
	input  payload_t push_data,
	output logic     space,
	output logic     space2,
	output payload_t out_data,
	output logic     out_valid,
	input  logic     out_ready
);

	payload_t mem [rf_ctl_pkg::FIFO_DEPTH];
	// Pointers wrap on their own, depth is a power of two
	logic [$clog2(rf_ctl_pkg::FIFO_DEPTH)-1:0]   wr_ptr;
	logic [$clog2(rf_ctl_pkg::FIFO_DEPTH)-1:0]   rd_ptr;
	logic [$clog2(rf_ctl_pkg::FIFO_DEPTH+1)-1:0] count;
	logic do_push;
	logic do_pop;

	// Free space flags for the producer
	assign space  = count < rf_ctl_pkg::FIFO_DEPTH;
	assign space2 = count <= rf_ctl_pkg::FIFO_DEPTH - 2;

	// Head of queue straight from the array
	assign out_valid = count != '0;
	assign out_data  = mem[rd_ptr];

	// Push into a full FIFO is ignored
	assign do_push = push & space;
	assign do_pop  = out_valid & out_ready;

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	always_ff @(posedge clk) begin
		if (ctlr_ph_reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// Occupancy
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// File: verilog/rf_controller.sv
`timescale 1ns/1ps

module rf_controller (
	input  logic               clk,
	input  logic               ctlr_ph_reset,
	input  rf_dsp_pkg::adc_t   a_field,
	input  logic [16:0]        iq_recv,
	input  logic               qsync_rx,
	input  logic [1:0]         use_fiber_iq,
	input  logic [31:0]        phase_step,
	input  logic [11:0]        modulo,
	input  logic [7:0]         wave_samp_per,
	input  logic [2:0]         wave_shift,
	input  logic signed [15:0] gain,
	input  rf_dsp_pkg::xy_t    set_x,
	input  rf_dsp_pkg::xy_t    set_y,
	output logic               iq,
	output rf_dsp_pkg::drive_t drive,
	output logic               cic_tick,
	output rf_dsp_pkg::mon_t   mon_result,
	output logic               mon_boundary,
	output logic               mon_valid,
	input  logic               mon_ready,
	output rf_dsp_pkg::drive_t trace_out,
	output logic               trace_valid,
	input  logic               trace_ready,
	output logic               mon_overrun,
	output logic               trace_overrun
);

	logic                  wave_strobe;
	logic                  dds_reset;
	rf_dsp_pkg::lo_t       cosa;
	rf_dsp_pkg::lo_t       sina;
	rf_dsp_pkg::xy_t       field_xy;
	rf_dsp_pkg::xy_t       fdbk_in;
	rf_dsp_pkg::mon_t      dec_mon_data;
	logic                  dec_mon_boundary;
	logic                  mon_push;
	logic                  mon_space2;
	rf_dsp_pkg::drive_t    trace_data;
	logic                  trace_push;
	logic                  trace_space;
	rf_dsp_pkg::mon_word_t mon_in;
	rf_dsp_pkg::mon_word_t mon_out;

	// State divider, CIC tick and phase realignment
	rf_timing timing (
		.clk(clk), .ctlr_ph_reset(ctlr_ph_reset),
		.qsync_rx(qsync_rx), .use_fiber_iq(use_fiber_iq),
		.wave_samp_per(wave_samp_per),
		.iq(iq), .cic_tick(cic_tick),
		.wave_strobe(wave_strobe), .dds_reset(dds_reset)
	);

	// Local oscillator
	phase_dds dds (
		.clk(clk), .ctlr_ph_reset(ctlr_ph_reset), .dds_reset(dds_reset),
		.phase_step(phase_step), .modulo(modulo),
		.cosa(cosa), .sina(sina)
	);

	// Field ADC to interleaved baseband
	iq_downconvert down (
		.clk(clk), .ctlr_ph_reset(ctlr_ph_reset), .iq(iq),
		.a_field(a_field), .cosa(cosa), .sina(sina),
		.field_xy(field_xy)
	);

	// Fiber I/Q is 17 bits, pad one LSB
	assign fdbk_in = use_fiber_iq[0] ? {iq_recv, 1'b0} : field_xy;

	fdbk_prop fdbk (
		.clk(clk), .ctlr_ph_reset(ctlr_ph_reset), .iq(iq),
		.in_xy(fdbk_in), .set_x(set_x), .set_y(set_y), .gain(gain),
		.out_xy(drive)
	);

	// Decimated capture into the two streams
	wave_decimator decim (
		.clk(clk), .ctlr_ph_reset(ctlr_ph_reset),
		.wave_strobe(wave_strobe), .iq(iq),
		.in_xy(fdbk_in), .drive(drive), .wave_shift(wave_shift),
		.mon_data(dec_mon_data), .mon_boundary(dec_mon_boundary),
		.mon_push(mon_push), .mon_space2(mon_space2),
		.trace_data(trace_data), .trace_push(trace_push),
		.trace_space(trace_space),
		.mon_overrun(mon_overrun), .trace_overrun(trace_overrun)
	);

	// Boundary bit rides with the monitor word
	assign mon_in.boundary = dec_mon_boundary;
	assign mon_in.data     = dec_mon_data;

	stream_fifo #(.payload_t(rf_dsp_pkg::mon_word_t)) mon_fifo (
		.clk(clk), .ctlr_ph_reset(ctlr_ph_reset),
		.push(mon_push), .push_data(mon_in),
		.space(), .space2(mon_space2),
		.out_data(mon_out), .out_valid(mon_valid), .out_ready(mon_ready)
	);

	assign mon_result   = mon_out.data;
	assign mon_boundary = mon_out.boundary;

	stream_fifo #(.payload_t(rf_dsp_pkg::drive_t)) trace_fifo (
		.clk(clk), .ctlr_ph_reset(ctlr_ph_reset),
		.push(trace_push), .push_data(trace_data),
		.space(trace_space), .space2(),
		.out_data(trace_out), .out_valid(trace_valid), .out_ready(trace_ready)
	);

endmodule

// File: tests/tb_rf_controller.sv
`timescale 1ns/1ps

module tb_rf_controller;

	logic               clk;
	logic               ctlr_ph_reset;
	rf_dsp_pkg::adc_t   a_field;
	logic [16:0]        iq_recv;
	logic               qsync_rx;
	logic [1:0]         use_fiber_iq;
	logic [31:0]        phase_step;
	logic [11:0]        modulo;
	logic [7:0]         wave_samp_per;
	logic [2:0]         wave_shift;
	logic signed [15:0] gain;
	rf_dsp_pkg::xy_t    set_x;
	rf_dsp_pkg::xy_t    set_y;
	logic               iq;
	rf_dsp_pkg::drive_t drive;
	logic               cic_tick;
	rf_dsp_pkg::mon_t   mon_result;
	logic               mon_boundary;
	logic               mon_valid;
	logic               mon_ready;
	rf_dsp_pkg::drive_t trace_out;
	logic               trace_valid;
	logic               trace_ready;
	logic               mon_overrun;
	logic               trace_overrun;

	int mismatches;
	int failures;
	// Reference state divider and drive pipeline
	logic [2:0] model_state;
	longint     exp_d1;
	longint     exp_d2;
	logic       v_d1;
	logic       v_d2;
	int         cic_gap;
	logic       cic_seen;
	logic       mon_ovr_seen;
	logic       trace_ovr_seen;
	// Phase enables and stream expectations
	logic               local_chk;
	logic               stream_chk;
	logic               hold_chk;
	logic               pair_recv;
	logic               rand_recv;
	logic               rand_ready;
	longint             local_exp_i;
	logic [16:0]        recv_i;
	logic [16:0]        recv_q;
	int                 exp_mon_i;
	int                 exp_mon_q;
	longint             exp_tr_i;
	longint             exp_tr_q;
	logic               expect_i;
	int                 pairs;
	int                 mon_words;
	int                 trace_words;
	rf_dsp_pkg::mon_t   held_mon;
	logic               held_b;
	rf_dsp_pkg::drive_t held_tr;

	rf_controller DUT (
		.clk(clk), .ctlr_ph_reset(ctlr_ph_reset), .a_field(a_field),
		.iq_recv(iq_recv), .qsync_rx(qsync_rx), .use_fiber_iq(use_fiber_iq),
		.phase_step(phase_step), .modulo(modulo), .wave_samp_per(wave_samp_per),
		.wave_shift(wave_shift), .gain(gain), .set_x(set_x), .set_y(set_y),
		.iq(iq), .drive(drive), .cic_tick(cic_tick),
		.mon_result(mon_result), .mon_boundary(mon_boundary),
		.mon_valid(mon_valid), .mon_ready(mon_ready),
		.trace_out(trace_out), .trace_valid(trace_valid), .trace_ready(trace_ready),
		.mon_overrun(mon_overrun), .trace_overrun(trace_overrun)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Error times gain, shift, clip
	function automatic longint fdbk_expect(longint setpt, longint x, longint g);
		longint p;
		p = ((setpt - x) * g) >>> rf_dsp_pkg::FDBK_SHIFT;
		if (p > rf_dsp_pkg::DRIVE_MAX) begin
			p = rf_dsp_pkg::DRIVE_MAX;
		end else if (p < -rf_dsp_pkg::DRIVE_MAX) begin
			p = -rf_dsp_pkg::DRIVE_MAX;
		end
		return p;
	endfunction

	// Fiber word gets one zero LSB
	function automatic longint fiber_word(logic [16:0] r);
		return longint'($signed({r, 1'b0}));
	endfunction

	function automatic int mon_expect(logic [16:0] r, logic [2:0] sh);
		int x;
		x = int'(fiber_word(r));
		return x >>> sh;
	endfunction

	// Mixer at zero phase, round half up from bit 15
	function automatic longint mix_expect(longint a);
		return (a * rf_ctl_pkg::LO_AMP + 16384) >>> 15;
	endfunction

	task automatic flag_mismatch(string sig, longint got, longint exp);
		mismatches++;
		$display("Mismatch at %0t: %s got %0d expected %0d", $time, sig, got, exp);
	endtask

	task automatic flag_failure(string msg);
		failures++;
		$display("Error at %0t: %s", $time, msg);
	endtask

	task automatic finish_run();
		$display("Error counts: %0d mismatches, %0d other failures", mismatches, failures);
		if (mismatches == 0 && failures == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	endtask

	// One falling edge per cycle, fiber word and ready patterns
	task automatic step_cycles(int n);
		repeat (n) begin
			@(negedge clk);
			if (pair_recv) begin
				iq_recv = model_state[0] ? recv_q : recv_i;
			end else if (rand_recv) begin
				iq_recv = 17'($urandom);
			end
			if (rand_ready) begin
				mon_ready   = 1'($urandom);
				trace_ready = 1'($urandom);
			end
		end
	endtask

	task automatic apply_reset();
		@(negedge clk);
		ctlr_ph_reset = 1'b1;
		repeat (5) @(negedge clk);
		ctlr_ph_reset = 1'b0;
	endtask

	task automatic wait_cic_tick(int limit);
		int n;
		n = 0;
		while (!cic_tick) begin
			step_cycles(1);
			n++;
			if (n > limit) begin
				flag_failure("timeout waiting for cic_tick");
				finish_run();
			end
		end
	endtask

	// Load on sync, then iq is bit 0 of the loaded state
	task automatic sync_check(logic swap);
		logic exp_iq;
		exp_iq = swap ? rf_ctl_pkg::SYNC_STATE_SWAP[0] : rf_ctl_pkg::SYNC_STATE_NORMAL[0];
		step_cycles(1);
		// Pulse where a missed load would leave the other iq
		if (model_state[0] != exp_iq) begin
			step_cycles(1);
		end
		use_fiber_iq = {swap, 1'b1};
		qsync_rx     = 1'b1;
		step_cycles(1);
		qsync_rx = 1'b0;
		assert (iq == exp_iq) else flag_mismatch("iq", iq, exp_iq);
		step_cycles(6);
	endtask

	task automatic saturation_check(rf_dsp_pkg::xy_t setpt, logic [16:0] recv,
		logic signed [15:0] g, longint exp);
		set_x   = setpt;
		set_y   = setpt;
		iq_recv = recv;
		gain    = g;
		step_cycles(4);
		assert (drive == exp) else flag_mismatch("drive", drive, exp);
	endtask

	// CIC tick lasts one clock
	cic_pulse_width: assert property (@(posedge clk) disable iff (ctlr_ph_reset)
		cic_tick |=> !cic_tick) else flag_failure("cic_tick high for more than one clock");

	// Reference model, sampled before the edge updates
	always @(posedge clk) begin
		if (ctlr_ph_reset) begin
			model_state    = 3'd0;
			v_d1           = 1'b0;
			v_d2           = 1'b0;
			cic_seen       = 1'b0;
			mon_ovr_seen   = 1'b0;
			trace_ovr_seen = 1'b0;
		end else begin
			assert (iq == model_state[0]) else flag_mismatch("iq", iq, model_state[0]);
			if (v_d2) begin
				assert (drive == exp_d2) else flag_mismatch("drive", drive, exp_d2);
			end
			// Zero phase LO, Q product is zero
			if (local_chk) begin
				assert (drive == (model_state[0] ? 0 : local_exp_i))
					else flag_mismatch("drive", drive, model_state[0] ? 0 : local_exp_i);
			end
			exp_d2 = exp_d1;
			v_d2   = v_d1;
			exp_d1 = fdbk_expect(model_state[0] ? set_y : set_x, fiber_word(iq_recv), gain);
			v_d1   = use_fiber_iq[0];
			if (cic_tick) begin
				if (cic_seen) begin
					assert (cic_gap == rf_ctl_pkg::CIC_BASE_PERIOD)
						else flag_mismatch("cic_tick period", cic_gap, rf_ctl_pkg::CIC_BASE_PERIOD);
				end
				cic_seen = 1'b1;
				cic_gap  = 1;
			end else begin
				cic_gap++;
			end
			// Overrun flags are sticky
			if (mon_ovr_seen) begin
				assert (mon_overrun) else flag_failure("mon_overrun cleared without reset");
			end
			if (trace_ovr_seen) begin
				assert (trace_overrun) else flag_failure("trace_overrun cleared without reset");
			end
			mon_ovr_seen   = mon_ovr_seen | mon_overrun;
			trace_ovr_seen = trace_ovr_seen | trace_overrun;
			if (qsync_rx && use_fiber_iq[0]) begin
				model_state = use_fiber_iq[1] ? rf_ctl_pkg::SYNC_STATE_SWAP
					: rf_ctl_pkg::SYNC_STATE_NORMAL;
			end else begin
				model_state = model_state + 3'd1;
			end
		end
	end

	// Stream transfers on valid and ready at the edge
	always @(posedge clk) begin
		if (stream_chk && mon_valid && mon_ready) begin
			mon_words++;
			if (expect_i) begin
				assert (mon_boundary) else flag_mismatch("mon_boundary", mon_boundary, 1);
				assert (mon_result == exp_mon_i) else flag_mismatch("mon_result", mon_result, exp_mon_i);
			end else begin
				assert (!mon_boundary) else flag_mismatch("mon_boundary", mon_boundary, 0);
				assert (mon_result == exp_mon_q) else flag_mismatch("mon_result", mon_result, exp_mon_q);
				pairs++;
			end
			expect_i = !expect_i;
		end
		if (stream_chk && trace_valid && trace_ready) begin
			trace_words++;
			// Strobe may land on either half of the pair
			assert (trace_out == exp_tr_i || trace_out == exp_tr_q) else begin
				mismatches++;
				$display("Mismatch at %0t: trace_out got %0d expected %0d or %0d",
					$time, trace_out, exp_tr_i, exp_tr_q);
			end
		end
		// Head of queue frozen under back-pressure
		if (hold_chk) begin
			assert (mon_valid && trace_valid) else flag_failure("valid dropped while ready low");
			assert (mon_result == held_mon) else flag_mismatch("mon_result", mon_result, held_mon);
			assert (mon_boundary == held_b) else flag_mismatch("mon_boundary", mon_boundary, held_b);
			assert (trace_out == held_tr) else flag_mismatch("trace_out", trace_out, held_tr);
		end
	end

	initial begin
		int n;
		void'($urandom(28));
		mismatches    = 0;
		failures      = 0;
		cic_gap       = 0;
		ctlr_ph_reset = 1'b1;
		a_field       = 16'sd8000;
		iq_recv       = '0;
		qsync_rx      = 1'b0;
		use_fiber_iq  = 2'b00;
		phase_step    = '0;
		modulo        = '0;
		wave_samp_per = 8'd1;
		wave_shift    = '0;
		gain          = 16'sd1 <<< rf_dsp_pkg::FDBK_SHIFT;
		set_x         = '0;
		set_y         = '0;
		mon_ready     = 1'b0;
		trace_ready   = 1'b0;
		{local_chk, stream_chk, hold_chk} = 3'b000;
		{pair_recv, rand_recv, rand_ready} = 3'b000;
		expect_i      = 1'b1;
		pairs         = 0;
		mon_words     = 0;
		trace_words   = 0;
		local_exp_i = fdbk_expect(0, mix_expect(a_field), gain);

		// LO turns after reset, only the tick realignment brings it to zero phase
		phase_step = 32'h0100_0000;
		// Local path after realignment, unity gain
		apply_reset();
		assert (!cic_tick && !mon_valid && !trace_valid && !mon_overrun && !trace_overrun
			&& drive == 0) else flag_failure("outputs not cleared by reset");
		wait_cic_tick(100);
		// Phase frozen from here, cleared by the pending realignment
		phase_step = '0;
		step_cycles(8);
		local_chk = 1'b1;
		step_cycles(4 * rf_ctl_pkg::CIC_BASE_PERIOD);
		local_chk = 1'b0;

		// Fiber sync, normal then swapped order
		sync_check(1'b0);
		sync_check(1'b1);
		use_fiber_iq = 2'b01;

		// Random fiber words, setpoints and gains
		rand_recv = 1'b1;
		set_x     = 18'($urandom);
		set_y     = 18'($urandom);
		gain      = 16'($urandom);
		step_cycles(60);
		gain = 16'($urandom % 512);
		step_cycles(60);
		rand_recv = 1'b0;

		saturation_check(18'sd131071, 17'h10000, 16'sd32767, rf_dsp_pkg::DRIVE_MAX);
		saturation_check(-18'sd131072, 17'h0ffff, 16'sd32767, -rf_dsp_pkg::DRIVE_MAX);

		// Monitor and trace streams, random ready
		recv_i        = 17'($urandom);
		recv_q        = 17'($urandom);
		wave_shift    = 3'($urandom);
		wave_samp_per = 8'($urandom % 3 + 2);
		set_x         = '0;
		set_y         = '0;
		gain          = 16'sd1 <<< rf_dsp_pkg::FDBK_SHIFT;
		exp_mon_i     = mon_expect(recv_i, wave_shift);
		exp_mon_q     = mon_expect(recv_q, wave_shift);
		exp_tr_i      = fdbk_expect(set_x, fiber_word(recv_i), gain);
		exp_tr_q      = fdbk_expect(set_y, fiber_word(recv_q), gain);
		pair_recv     = 1'b1;
		apply_reset();
		expect_i   = 1'b1;
		stream_chk = 1'b1;
		rand_ready = 1'b1;
		step_cycles(2 * rf_ctl_pkg::CIC_BASE_PERIOD);
		pairs = 0;
		step_cycles(6 * wave_samp_per * rf_ctl_pkg::CIC_BASE_PERIOD);
		assert (pairs >= 5 && pairs <= 7)
			else flag_failure($sformatf("%0d monitor pairs over six strobes", pairs));

		// Back-pressure until both FIFOs overrun
		rand_ready    = 1'b0;
		mon_ready     = 1'b0;
		trace_ready   = 1'b0;
		wave_samp_per = 8'd1;
		apply_reset();
		expect_i = 1'b1;
		n = 0;
		while (!(mon_valid && trace_valid)) begin
			step_cycles(1);
			n++;
			if (n > 200) begin
				flag_failure("timeout waiting for monitor and trace data");
				finish_run();
			end
		end
		held_mon = mon_result;
		held_b   = mon_boundary;
		held_tr  = trace_out;
		hold_chk = 1'b1;
		n = 0;
		while (!(mon_overrun && trace_overrun)) begin
			step_cycles(1);
			n++;
			if (n > 2000) begin
				flag_failure("timeout waiting for both overrun flags");
				finish_run();
			end
		end
		step_cycles(3 * rf_ctl_pkg::CIC_BASE_PERIOD);
		hold_chk = 1'b0;

		// Drain just after a strobe, before the next one
		wait_cic_tick(100);
		mon_words   = 0;
		trace_words = 0;
		mon_ready   = 1'b1;
		trace_ready = 1'b1;
		step_cycles(20);
		mon_ready   = 1'b0;
		trace_ready = 1'b0;
		assert (mon_words <= rf_ctl_pkg::FIFO_DEPTH && trace_words <= rf_ctl_pkg::FIFO_DEPTH)
			else flag_failure("more words drained than the FIFO holds");
		assert (mon_words % 2 == 0 && mon_words > 0)
			else flag_failure("monitor drain did not end on a whole pair");
		stream_chk = 1'b0;
		finish_run();
	end

endmodule

// File: verilog.f
+incdir+verilog
verilog/rf_dsp_pkg.sv
verilog/rf_ctl_pkg.sv
verilog/rf_timing.sv
verilog/phase_dds.sv
verilog/iq_downconvert.sv
verilog/fdbk_prop.sv
verilog/wave_decimator.sv
verilog/stream_fifo.sv
verilog/rf_controller.sv
tests/tb_rf_controller.sv

// File: Bender.yml
package:
  name: rf_controller

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/rf_dsp_pkg.sv
      - verilog/rf_ctl_pkg.sv
      - verilog/rf_timing.sv
      - verilog/phase_dds.sv
      - verilog/iq_downconvert.sv
      - verilog/fdbk_prop.sv
      - verilog/wave_decimator.sv
      - verilog/stream_fifo.sv
      - verilog/rf_controller.sv
  - target: test
    files:
      - tests/tb_rf_controller.sv
